/* common/l1_pkg.sv */
// Cache geometry is fixed here; changing IDX_WIDTH or ADDR_WIDTH resizes every block at once

package l1_pkg;

  // ##########################################################
  // Address and data geometry
  // ##########################################################

  // Word addressed, no byte lanes
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;  // One word per line

  // Associativity
  localparam int WAY_NUM = 4;

  // Set index taken from the low address bits
  localparam int IDX_WIDTH = 4;
  localparam int SET_NUM   = 1 << IDX_WIDTH;  // 16 sets

  // Tag is whatever is left above the index
  localparam int TAG_WIDTH = ADDR_WIDTH - IDX_WIDTH;  // 12 bits

  // ##########################################################
  // Controller states
  // ##########################################################

  // One request in flight at a time
  typedef enum logic [2:0] {
    ST_IDLE,    // Waiting for cpu_req, latches request and fires tag read
    ST_LOOKUP,  // Tag result arrives, hit or miss decided
    ST_MEM,     // Memory handshake, read refill or write-through
    ST_FILL,    // Refill word written into tag, data and LRU state
    ST_RESP     // cpu_ack high until the CPU drops cpu_req
  } l1_state_e;

  // Memory traffic happens on
  //   read miss   -> one memory read, then FILL
  //   write hit   -> array write plus one memory write
  //   write miss  -> one memory write, no allocation
  // Read hits never touch memory

endpackage

/* l1_cache/l1_tag_array.sv */
// Registered tag compare; fill_way must be one-hot and tag_rd is not issued in a fill cycle

`timescale 1ns/1ps

module l1_tag_array (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       tag_rd,       // Lookup strobe
  input  logic [l1_pkg::IDX_WIDTH-1:0] idx,
  input  logic [l1_pkg::TAG_WIDTH-1:0] tag,
  input  logic                       fill_we,      // Refill write strobe
  input  logic [l1_pkg::WAY_NUM-1:0] fill_way,     // One-hot victim way
  output logic [l1_pkg::WAY_NUM-1:0] tag_cmp_vect, // Per-way tag equality
  output logic [l1_pkg::WAY_NUM-1:0] vld_vect      // Per-way valid of the set
);

  import l1_pkg::*;

  // ##########################################################
  // Storage
  // ##########################################################

  logic [TAG_WIDTH-1:0] tag_mem [SET_NUM][WAY_NUM];  // Tags, no reset needed
  logic [WAY_NUM-1:0]   vld_r   [SET_NUM];           // Valid bits per set

  logic [WAY_NUM-1:0]   cmp_now;                      // Compare before the register

  // Tag equality for every way of the addressed set
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      cmp_now[w] = (tag_mem[idx][w] == tag);
    end
  end

  // Tag write on refill
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAY_NUM; w++) begin
      if (fill_we && fill_way[w]) tag_mem[idx][w] <= tag;
    end
  end

  // ##########################################################
  // Valid bits and registered lookup result
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SET_NUM; s++) begin
        vld_r[s] <= '0;  // Cache starts empty
      end
      tag_cmp_vect <= '0;
      vld_vect     <= '0;
    end else begin
      if (fill_we) vld_r[idx] <= vld_r[idx] | fill_way;  // Mark refilled way
      if (tag_rd) begin
        tag_cmp_vect <= cmp_now;      // Result valid the cycle after strobe
        vld_vect     <= vld_r[idx];
      end
      // Outputs hold between strobes so the LRU sees a stable view
    end
  end

  // Refill must pick exactly one way, the controller takes it from l1_lru
  a_fill_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    fill_we |-> $onehot(fill_way)
  ) else $error("fill_way not one-hot during fill");

endmodule

/* l1_cache/l1_lru.sv */
// MRU-bit pseudo-LRU; used bits never all set, hit and way_vect are combinational from the tag array

`timescale 1ns/1ps

module l1_lru (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lru_upd,      // Touch the selected way
  input  logic [l1_pkg::IDX_WIDTH-1:0] idx,
  input  logic [l1_pkg::WAY_NUM-1:0]   tag_cmp_vect,
  input  logic [l1_pkg::WAY_NUM-1:0]   vld_vect,
  output logic                         hit,
  output logic [l1_pkg::WAY_NUM-1:0]   way_vect      // Hit way or victim
);

  import l1_pkg::*;

  logic [WAY_NUM-1:0] used_r [SET_NUM];  // One used bit per way and set

  logic [WAY_NUM-1:0] used_set;     // Used bits of the addressed set
  logic [WAY_NUM-1:0] hit_vect;
  logic [WAY_NUM-1:0] victim_vect;
  logic [WAY_NUM-1:0] used_or;      // Used bits with the selected way added
  logic [WAY_NUM-1:0] used_nxt;

  // Keeps only the highest set bit, zero in gives zero out
  function automatic logic [WAY_NUM-1:0] ms1_vec(input logic [WAY_NUM-1:0] vec);
    logic [WAY_NUM-1:0] res;
    res = '0;
    for (int i = 0; i < WAY_NUM; i++) begin
      if (vec[i]) begin
        res    = '0;
        res[i] = 1'b1;  // Later (higher) bits overwrite earlier ones
      end
    end
    return res;
  endfunction

  // ##########################################################
  // Hit detection and way selection
  // ##########################################################

  assign used_set = used_r[idx];
  assign hit_vect = vld_vect & tag_cmp_vect;
  assign hit      = |hit_vect;

  // Free way first, else highest way not recently used
  // With no used bit set ~used_set is all ones, so the top way wins
  assign victim_vect = (&vld_vect) ? ms1_vec(~used_set) : ms1_vec(~vld_vect);
  assign way_vect    = hit ? hit_vect : victim_vect;

  // Saturation resets the set to only the newest way
  assign used_or  = used_set | way_vect;
  assign used_nxt = (&used_or) ? way_vect : used_or;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SET_NUM; s++) begin
        used_r[s] <= '0;
      end
    end else if (lru_upd) begin
      used_r[idx] <= used_nxt;
    end
  end

  // The controller only updates after a lookup has resolved
  a_upd_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    lru_upd |-> $onehot(way_vect)
  ) else $error("way_vect not one-hot on LRU update");

endmodule

/* l1_cache/l1_data_array.sv */
// Word storage with no reset; way_sel must be one-hot on both read and write

`timescale 1ns/1ps

module l1_data_array (
  input  logic                          clk,
  input  logic                          data_rd,  // Read strobe, data next cycle
  input  logic                          data_we,  // Write strobe
  input  logic [l1_pkg::IDX_WIDTH-1:0]  idx,
  input  logic [l1_pkg::WAY_NUM-1:0]    way_sel,  // One-hot way
  input  logic [l1_pkg::DATA_WIDTH-1:0] wdata,
  output logic [l1_pkg::DATA_WIDTH-1:0] rdata
);

  import l1_pkg::*;

  logic [DATA_WIDTH-1:0] mem_r [SET_NUM][WAY_NUM];
  logic [DATA_WIDTH-1:0] rd_mux;  // Selected way before the output register

  // ##########################################################
  // Way mux, AND-OR since way_sel is one-hot
  // ##########################################################

  always_comb begin
    rd_mux = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      rd_mux = rd_mux | (mem_r[idx][w] & {DATA_WIDTH{way_sel[w]}});
    end
  end

  // Write and registered read share the edge
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAY_NUM; w++) begin
      if (data_we && way_sel[w]) mem_r[idx][w] <= wdata;
    end
    if (data_rd) rdata <= rd_mux;  // Holds until the next read
  end

endmodule

/* l1_cache/l1_ctrl.sv */
// One request at a time; CPU and memory sides both assume a well-behaved four-phase partner

`timescale 1ns/1ps

module l1_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  // CPU side
  input  logic                          cpu_req,
  input  logic                          cpu_we,
  input  logic [l1_pkg::ADDR_WIDTH-1:0] cpu_addr,
  input  logic [l1_pkg::DATA_WIDTH-1:0] cpu_wdata,
  output logic                          cpu_ack,
  output logic [l1_pkg::DATA_WIDTH-1:0] cpu_rdata,
  // Memory side
  output logic                          mem_req,
  output logic                          mem_we,
  output logic [l1_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [l1_pkg::DATA_WIDTH-1:0] mem_wdata,
  input  logic                          mem_ack,
  input  logic [l1_pkg::DATA_WIDTH-1:0] mem_rdata,
  // Tag array and LRU
  output logic                          tag_rd,
  output logic [l1_pkg::IDX_WIDTH-1:0]  idx,
  output logic [l1_pkg::TAG_WIDTH-1:0]  tag,
  output logic                          fill_we,
  output logic [l1_pkg::WAY_NUM-1:0]    fill_way,
  output logic                          lru_upd,
  input  logic                          hit,
  input  logic [l1_pkg::WAY_NUM-1:0]    way_vect,
  // Data array
  output logic                          data_rd,
  output logic                          data_we,
  output logic [l1_pkg::WAY_NUM-1:0]    data_way,
  output logic [l1_pkg::DATA_WIDTH-1:0] data_wdata,
  input  logic [l1_pkg::DATA_WIDTH-1:0] data_rdata
);

  import l1_pkg::*;

  l1_state_e state_r;

  logic                  we_r;       // Latched cpu_we
  logic                  miss_r;     // Lookup outcome
  logic [ADDR_WIDTH-1:0] addr_r;     // Latched request address
  logic [DATA_WIDTH-1:0] wdata_r;    // Latched write data
  logic [WAY_NUM-1:0]    way_r;      // Victim for the refill
  logic                  lookup_go;  // Tag result valid this cycle
  logic                  in_fill;

  // ##########################################################
  // Array and LRU strobes
  // ##########################################################

  // First LOOKUP cycle still has tag_rd high, result comes a cycle later
  assign lookup_go = (state_r == ST_LOOKUP) && !tag_rd;
  assign in_fill   = (state_r == ST_FILL);

  assign idx      = addr_r[IDX_WIDTH-1:0];
  assign tag      = addr_r[ADDR_WIDTH-1:IDX_WIDTH];
  assign fill_we  = in_fill;
  assign fill_way = way_r;
  assign lru_upd  = (lookup_go && hit) || in_fill;  // Hit or refill touches the way
  assign data_rd  = lookup_go && hit && !we_r;      // Read hit
  assign data_we  = (lookup_go && hit && we_r) || in_fill;  // Write hit or refill
  assign data_way = in_fill ? way_r : way_vect;
  assign data_wdata = in_fill ? cpu_rdata : wdata_r;  // Refill word sits in cpu_rdata

  assign mem_addr  = addr_r;
  assign mem_wdata = wdata_r;

  // ##########################################################
  // Request FSM
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r <= ST_IDLE;
      tag_rd  <= 1'b0;
      we_r    <= 1'b0;
      miss_r  <= 1'b0;
      cpu_ack <= 1'b0;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      tag_rd <= 1'b0;  // Single-cycle strobe
      case (state_r)
        ST_IDLE: begin
          if (cpu_req) begin
            we_r    <= cpu_we;
            tag_rd  <= 1'b1;
            state_r <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (!tag_rd) begin
            miss_r <= !hit;
            if (hit && !we_r) begin
              state_r <= ST_RESP;
            end else begin
              mem_req <= 1'b1;  // Refill read or write-through
              mem_we  <= we_r;
              state_r <= ST_MEM;
            end
          end
        end
        ST_MEM: begin
          if (mem_req) begin
            if (mem_ack) mem_req <= 1'b0;
          end else if (!mem_ack) begin
            state_r <= mem_we ? ST_RESP : ST_FILL;  // Only read misses refill
          end
        end
        ST_FILL: state_r <= ST_RESP;
        ST_RESP: begin
          if (!cpu_ack) begin
            if (cpu_req) cpu_ack <= 1'b1;
          end else if (!cpu_req) begin
            cpu_ack <= 1'b0;
            state_r <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // Request payload and response data
  always_ff @(posedge clk) begin
    if (state_r == ST_IDLE && cpu_req) begin
      addr_r  <= cpu_addr;
      wdata_r <= cpu_wdata;
    end
    if (lookup_go) way_r <= way_vect;
    if (state_r == ST_MEM && mem_req && mem_ack && !mem_we) cpu_rdata <= mem_rdata;
    if (state_r == ST_RESP && !cpu_ack && !we_r && !miss_r) cpu_rdata <= data_rdata;
  end

  a_mem_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(mem_req) |-> $past(mem_ack)
  ) else $error("mem_req dropped before mem_ack");

  a_ack_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cpu_ack) |-> $past(cpu_req)
  ) else $error("cpu_ack raised without cpu_req");

endmodule

/* rtl/l1_cache_top.sv */
// Blocking write-through cache, no write-allocate; CPU and memory ports use four-phase req/ack

`timescale 1ns/1ps

module l1_cache_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // CPU port
  input  logic                          cpu_req,
  input  logic                          cpu_we,
  input  logic [l1_pkg::ADDR_WIDTH-1:0] cpu_addr,
  input  logic [l1_pkg::DATA_WIDTH-1:0] cpu_wdata,
  output logic                          cpu_ack,
  output logic [l1_pkg::DATA_WIDTH-1:0] cpu_rdata,
  // Memory port
  output logic                          mem_req,
  output logic                          mem_we,
  output logic [l1_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [l1_pkg::DATA_WIDTH-1:0] mem_wdata,
  input  logic                          mem_ack,
  input  logic [l1_pkg::DATA_WIDTH-1:0] mem_rdata
);

  import l1_pkg::*;

  // ##########################################################
  // Internal nets
  // ##########################################################

  logic                  tag_rd;
  logic [IDX_WIDTH-1:0]  idx;
  logic [TAG_WIDTH-1:0]  tag;
  logic                  fill_we;
  logic [WAY_NUM-1:0]    fill_way;
  logic [WAY_NUM-1:0]    tag_cmp_vect;
  logic [WAY_NUM-1:0]    vld_vect;
  logic                  lru_upd;
  logic                  hit;
  logic [WAY_NUM-1:0]    way_vect;
  logic                  data_rd;
  logic                  data_we;
  logic [WAY_NUM-1:0]    data_way;
  logic [DATA_WIDTH-1:0] data_wdata;
  logic [DATA_WIDTH-1:0] data_rdata;

  l1_ctrl u_ctrl (.*);  // Port names match the nets one to one

  l1_tag_array u_tag_array (
    .clk, .rst_n, .tag_rd, .idx, .tag, .fill_we, .fill_way,
    .tag_cmp_vect, .vld_vect
  );

  l1_lru u_lru (
    .clk, .rst_n, .lru_upd, .idx, .tag_cmp_vect, .vld_vect,
    .hit, .way_vect
  );

  // Same one-hot way for refill victim and write hit
  l1_data_array u_data_array (
    .clk     (clk),
    .data_rd (data_rd),
    .data_we (data_we),
    .idx     (idx),
    .way_sel (data_way),
    .wdata   (data_wdata),
    .rdata   (data_rdata)
  );

endmodule

/* tests/l1_cache_tb.sv */
// Drives one CPU request at a time; memory model spans the full 16-bit word space, geometry from l1_pkg

`timescale 1ns/1ps

module l1_cache_tb;

  import l1_pkg::*;

  // ##########################################################
  // Run constants
  // ##########################################################

  localparam int          RESET_CYCLES = 8;
  localparam int          HIT_LATENCY  = 3;    // Edge that samples cpu_req to cpu_ack rise
  localparam int          NUM_DIRECTED = 12;
  localparam int          NUM_RAND     = 400;
  localparam int          NUM_REQ      = NUM_DIRECTED + NUM_RAND;
  localparam int          CYC_PER_REQ  = 20;   // Worst miss with a 5-cycle memory is ~13
  localparam int          WATCHDOG_CYC = NUM_REQ * CYC_PER_REQ + RESET_CYCLES;
  localparam int          WR_PERCENT   = 30;
  localparam logic [31:0] SEED         = 32'h78d52884;

  logic                  clk;
  logic                  rst_n;
  logic                  cpu_req;
  logic                  cpu_we;
  logic [ADDR_WIDTH-1:0] cpu_addr;
  logic [DATA_WIDTH-1:0] cpu_wdata;
  logic                  cpu_ack;
  logic [DATA_WIDTH-1:0] cpu_rdata;
  logic                  mem_req;
  logic                  mem_we;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0] mem_wdata;
  logic                  mem_ack;
  logic [DATA_WIDTH-1:0] mem_rdata;

  int                    err_cnt;
  int                    req_cnt;
  int                    rd_cnt;        // Completed memory reads
  int                    wr_cnt;        // Completed memory writes
  logic [ADDR_WIDTH-1:0] last_rd_addr;
  logic [ADDR_WIDTH-1:0] last_wr_addr;
  logic [DATA_WIDTH-1:0] last_wr_data;

  logic [DATA_WIDTH-1:0] mem_arr [0:(1<<ADDR_WIDTH)-1];  // Backing store

  // Reference cache state
  bit                    m_vld  [SET_NUM][WAY_NUM];
  logic [TAG_WIDTH-1:0]  m_tag  [SET_NUM][WAY_NUM];
  bit [WAY_NUM-1:0]      m_used [SET_NUM];

  // Previous samples for the handshake monitor
  logic                  ack_q;
  logic                  req_q;
  logic                  mreq_q;
  logic                  mack_q;

  l1_cache_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #50 clk = ~clk;  // 100 ns period

  // ##########################################################
  // Checking and reference model
  // ##########################################################

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
      err_cnt++;
    end
  endtask

  // Hit way, else highest free way, else highest way with used bit clear
  task automatic predict_lookup(input logic [ADDR_WIDTH-1:0] addr, output bit hit,
                                output int way);
    int                   s;
    logic [TAG_WIDTH-1:0] t;
    bit                   free;
    s    = addr[IDX_WIDTH-1:0];
    t    = addr[ADDR_WIDTH-1:IDX_WIDTH];
    hit  = 1'b0;
    free = 1'b0;
    way  = WAY_NUM - 1;  // Top way when no used bit is set
    for (int w = 0; w < WAY_NUM; w++) begin
      if (m_vld[s][w] && m_tag[s][w] == t) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        if (!m_vld[s][w]) begin
          way  = w;  // Ascending, so highest free way wins
          free = 1'b1;
        end
      end
      for (int w = 0; w < WAY_NUM && !free; w++) begin
        if (!m_used[s][w]) way = w;
      end
    end
  endtask

  // MRU bit set, all ones collapses to the newest way
  function automatic void touch_way(input int s, input int w);
    bit [WAY_NUM-1:0] nxt;
    nxt = m_used[s] | (WAY_NUM'(1) << w);
    if (&nxt) nxt = WAY_NUM'(1) << w;
    m_used[s] = nxt;
  endfunction

  // One four-phase CPU transaction, entered and left on a falling edge
  task automatic cpu_access(input bit we, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] wdata);
    bit                    m_hit;
    int                    m_way;
    int                    cyc;
    int                    rd0;
    int                    wr0;
    int                    s;
    logic [DATA_WIDTH-1:0] exp_data;
    predict_lookup(addr, m_hit, m_way);
    s         = addr[IDX_WIDTH-1:0];
    rd0       = rd_cnt;
    wr0       = wr_cnt;
    exp_data  = mem_arr[addr];  // Memory is always current under write-through
    cpu_req   = 1'b1;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cyc       = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (cpu_ack !== 1'b1);
    if (!we) begin
      check_val("cpu_rdata", exp_data, cpu_rdata);
      if (m_hit) check_val("hit latency", HIT_LATENCY, cyc - 1);  // Ack rose one edge earlier
    end
    cpu_req = 1'b0;
    while (cpu_ack !== 1'b0) @(negedge clk);
    if (we) begin
      check_val("mem writes", 1, wr_cnt - wr0);
      check_val("mem reads", 0, rd_cnt - rd0);
      check_val("mem_addr", addr, last_wr_addr);
      check_val("mem_wdata", wdata, last_wr_data);
      if (m_hit) touch_way(s, m_way);  // No allocate on write miss
    end else begin
      check_val("mem reads", m_hit ? 0 : 1, rd_cnt - rd0);
      check_val("mem writes", 0, wr_cnt - wr0);
      if (!m_hit) begin
        check_val("mem_addr", addr, last_rd_addr);
        m_vld[s][m_way] = 1'b1;  // Refill into the victim
        m_tag[s][m_way] = addr[ADDR_WIDTH-1:IDX_WIDTH];
      end
      touch_way(s, m_way);
    end
    req_cnt++;
  endtask

  // ##########################################################
  // Memory responder and handshake monitor
  // ##########################################################

  always begin : mem_model
    int unsigned dly;
    @(negedge clk);
    if (rst_n === 1'b1 && mem_req === 1'b1 && mem_ack === 1'b0) begin
      dly = $urandom_range(0, 5);
      repeat (dly) @(negedge clk);
      if (mem_we) begin
        mem_arr[mem_addr] = mem_wdata;
        wr_cnt++;
        last_wr_addr = mem_addr;
        last_wr_data = mem_wdata;
      end else begin
        mem_rdata = mem_arr[mem_addr];
        rd_cnt++;
        last_rd_addr = mem_addr;
      end
      mem_ack = 1'b1;
      while (mem_req === 1'b1) @(negedge clk);  // Hold ack until the cache releases
      mem_ack = 1'b0;
    end
  end

  // Pre-edge values; inputs change on the falling edge only
  always @(posedge clk) begin : hs_monitor
    if (rst_n === 1'b1) begin
      if (cpu_ack === 1'b1 && ack_q === 1'b0 && req_q !== 1'b1) begin
        $display("cpu_ack rose while cpu_req was low at %0t", $time);
        err_cnt++;
      end
      if (cpu_ack === 1'b0 && ack_q === 1'b1 && req_q !== 1'b0) begin
        $display("cpu_ack fell while cpu_req was still high at %0t", $time);
        err_cnt++;
      end
      if (mem_req === 1'b0 && mreq_q === 1'b1 && mack_q !== 1'b1) begin
        $display("mem_req dropped before mem_ack arrived at %0t", $time);
        err_cnt++;
      end
      if (mem_req === 1'b1 && mreq_q === 1'b0 && mack_q !== 1'b0) begin
        $display("mem_req rose while mem_ack was still high at %0t", $time);
        err_cnt++;
      end
    end
    ack_q  = cpu_ack;
    req_q  = cpu_req;
    mreq_q = mem_req;
    mack_q = mem_ack;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Run did not finish within %0d cycles, a handshake is stuck", WATCHDOG_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

  // ##########################################################
  // Stimulus
  // ##########################################################

  initial begin : stimulus
    logic [TAG_WIDTH-1:0]  dir_tag [5];
    logic [TAG_WIDTH-1:0]  tag_pool [6];
    logic [IDX_WIDTH-1:0]  set_pool [4];
    logic [IDX_WIDTH-1:0]  dir_set;
    logic [ADDR_WIDTH-1:0] addr;
    int                    victim;
    int                    rd_before;
    int                    w;
    bit                    h;
    void'($urandom(SEED));
    clk       = 1'b0;
    rst_n     = 1'b0;
    cpu_req   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    err_cnt   = 0;
    req_cnt   = 0;
    rd_cnt    = 0;
    wr_cnt    = 0;
    for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
      mem_arr[a] = $urandom ^ (a * 32'h9e37_79b9);  // Every address bit matters
    end
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (cpu_ack !== 1'b0 || mem_req !== 1'b0) begin
        $display("cpu_ack or mem_req not low during reset at %0t", $time);
        err_cnt++;
      end
    end
    rst_n = 1'b1;

    // Five tags into one set, then re-read with the victim last
    dir_set = 4'h7;
    dir_tag = '{12'h0a1, 12'h1b2, 12'h2c3, 12'h3d4, 12'h4e5};
    for (int i = 0; i < 5; i++) begin
      cpu_access(1'b0, {dir_tag[i], dir_set}, '0);
    end
    victim = 0;
    for (int i = 0; i < 5; i++) begin
      predict_lookup({dir_tag[i], dir_set}, h, w);
      if (!h) victim = i;
    end
    rd_before = rd_cnt;
    for (int i = 0; i < 5; i++) begin
      if (i != victim) cpu_access(1'b0, {dir_tag[i], dir_set}, '0);
    end
    cpu_access(1'b0, {dir_tag[victim], dir_set}, '0);
    check_val("refills on re-read", 1, rd_cnt - rd_before);

    // Write hit then read back from the cache
    addr = {dir_tag[victim], dir_set};
    cpu_access(1'b1, addr, 32'hc0de_5a17);
    cpu_access(1'b0, addr, '0);

    // Random traffic, six tags over four sets forces evictions
    for (int i = 0; i < 6; i++) begin
      tag_pool[i] = {8'($urandom), 4'(i)};  // Low nibble keeps tags distinct
    end
    set_pool = '{4'h0, 4'h5, 4'ha, 4'hf};
    for (int n = 0; n < NUM_RAND; n++) begin
      addr = {tag_pool[$urandom_range(0, 5)], set_pool[$urandom_range(0, 3)]};
      if ($urandom_range(0, 99) < WR_PERCENT) begin
        cpu_access(1'b1, addr, $urandom);
      end else begin
        cpu_access(1'b0, addr, '0);
      end
      if ($urandom_range(0, 3) == 0) @(negedge clk);  // Occasional idle cycle
    end

    repeat (2) @(negedge clk);
    $display("Run complete: %0d requests, %0d errors", req_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* l1_cache_top.f */
common/l1_pkg.sv
l1_cache/l1_tag_array.sv
l1_cache/l1_lru.sv
l1_cache/l1_data_array.sv
l1_cache/l1_ctrl.sv
rtl/l1_cache_top.sv
tests/l1_cache_tb.sv

/* Bender.yml */
package:
  name: l1_cache

sources:
  # Shared package first
  - common/l1_pkg.sv
  # Cache blocks
  - l1_cache/l1_tag_array.sv
  - l1_cache/l1_lru.sv
  - l1_cache/l1_data_array.sv
  - l1_cache/l1_ctrl.sv
  # Top level
  - rtl/l1_cache_top.sv
  # Testbench
  - target: test
    files:
      - tests/l1_cache_tb.sv
